//--- dv/noc_router_stim.txt
# P start_cycle in_port src dest data(hex) out_port, where out_port equal to in_port means dropped
# F start_cycle free_outbound_mask(hex), and B in_port that must see its free_inbound held low
F 0 f
P 10 0 8 1 a00001 2
P 10 1 9 0 b00002 0
P 10 2 a 2 c00003 3
P 10 3 b 3 d00004 1
P 30 0 8 2 a00005 3
P 30 0 8 3 a00006 1
P 30 0 8 7 a00007 1
P 30 0 8 f a00008 1
P 30 3 b 1 d0000a 2
# Own-port routes
P 40 0 8 0 a0000b 0
P 40 2 a 1 c0000c 2
P 40 1 9 4 b00009 1
# Three inputs to output 1 at once
P 80 0 8 5 a10001 1
P 80 2 a 5 c10001 1
P 80 3 b 5 d10001 1
P 80 0 8 6 a10002 1
P 80 2 a 6 c10002 1
P 80 3 b 6 d10002 1
# Output 3 blocked while input 1 overfills its queue
F 150 7
B 1
P 160 1 9 2 b20000 3
P 160 1 9 2 b20001 3
P 160 1 9 2 b20002 3
P 160 1 9 2 b20003 3
P 160 1 9 2 b20004 3
P 160 1 9 2 b20005 3
P 160 1 9 2 b20006 3
P 160 1 9 2 b20007 3
P 160 1 9 2 b20008 3
P 160 1 9 2 b20009 3
P 170 0 8 1 a20001 2
P 170 2 a 0 c20001 0
F 400 f

//--- build.f
hw/noc_pkg.sv
hw/packet_fifo.sv
hw/input_port.sv
hw/output_port.sv
hw/noc_router.sv
dv/noc_router_properties.sv
dv/noc_router_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the router testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module noc_router_tb \
    -f build.f \
    -o noc_router_sim

./obj_dir/noc_router_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation passed"

//--- dv/noc_router_tb.sv
`timescale 1ns/1ps

module noc_router_tb import noc_pkg::*; ();

    logic                  clock;
    logic                  reset_n;
    logic  [num_ports-1:0] put_inbound;
    byte_t [num_ports-1:0] payload_inbound;
    logic  [num_ports-1:0] free_outbound;
    logic  [num_ports-1:0] free_inbound;
    logic  [num_ports-1:0] put_outbound;
    byte_t [num_ports-1:0] payload_outbound;

    // Pending packets per input, expected packets per input and output pair
    int                   pend_start [num_ports][$];
    pkt_t                 pend_word [num_ports][$];
    pkt_t                 exp_q [num_ports][num_ports][$];
    int                   mask_cycle [$];
    logic [num_ports-1:0] mask_val [$];
    int                   port_of_src [16];
    bit                   stall_expected [num_ports];

    int                   tx_cnt [num_ports];
    logic [31:0]          tx_word [num_ports];
    int                   rx_cnt [num_ports];
    logic [31:0]          rx_word [num_ports];
    int                   low_run [num_ports];
    int                   max_low [num_ports];

    int cycle;
    int last_cycle;
    int first_start;
    int mismatches;
    int other_errors;
    int sent;
    int received;
    int blocked_arrivals;
    bit timed_out;

    noc_router #(
        .router_id (0)
    ) i_noc_router (
        .clock            (clock),
        .reset_n          (reset_n),
        .put_inbound      (put_inbound),
        .payload_inbound  (payload_inbound),
        .free_outbound    (free_outbound),
        .free_inbound     (free_inbound),
        .put_outbound     (put_outbound),
        .payload_outbound (payload_outbound)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            mismatches++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus file
    // ------------------------------------------------------------------------
    task automatic load_stimulus();
        int    fd;
        int    n;
        int    c;
        int    p;
        int    s;
        int    d;
        int    data;
        int    e;
        int    m;
        string line;
        pkt_t  pkt;
        for (int i = 0; i < 16; i++) begin
            port_of_src[i] = -1;
        end
        fd = $fopen("dv/noc_router_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/noc_router_stim.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2) begin
                    n = 0;
                end else if (line.getc(0) == "P") begin
                    n = $sscanf(line, "P %d %d %h %h %h %d", c, p, s, d, data, e);
                    pkt = pkt_t'({s[3:0], d[3:0], data[23:0]});
                    pend_start[p].push_back(c);
                    pend_word[p].push_back(pkt);
                    port_of_src[s[3:0]] = p;
                    // Route back to the arrival port is discarded
                    if (e != p) begin
                        exp_q[p][e].push_back(pkt);
                    end
                    if (c < first_start) begin
                        first_start = c;
                    end
                    if (c > last_cycle) begin
                        last_cycle = c;
                    end
                end else if (line.getc(0) == "F") begin
                    n = $sscanf(line, "F %d %h", c, m);
                    mask_cycle.push_back(c);
                    mask_val.push_back(m[num_ports-1:0]);
                    if (c > last_cycle) begin
                        last_cycle = c;
                    end
                end else if (line.getc(0) == "B") begin
                    n = $sscanf(line, "B %d", p);
                    stall_expected[p] = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // Drivers called 1 ns after each rising edge
    // ------------------------------------------------------------------------
    task automatic drive_inputs();
        while (mask_cycle.size() > 0 && mask_cycle[0] <= cycle) begin
            free_outbound = mask_val.pop_front();
            void'(mask_cycle.pop_front());
        end
        for (int p = 0; p < num_ports; p++) begin
            put_inbound[p] = 1'b0;
            if (tx_cnt[p] > 0) begin
                payload_inbound[p] = tx_word[p][8*tx_cnt[p]-1 -: 8];
                tx_cnt[p]--;
            end else if (pend_start[p].size() > 0 && pend_start[p][0] <= cycle
                         && free_inbound[p]) begin
                tx_word[p] = pend_word[p].pop_front();
                void'(pend_start[p].pop_front());
                put_inbound[p]     = 1'b1;
                payload_inbound[p] = tx_word[p][31:24];
                tx_cnt[p]          = 3;
                sent++;
            end
            // Longest stretch without free_inbound
            if (free_inbound[p]) begin
                low_run[p] = 0;
            end else begin
                low_run[p]++;
                if (low_run[p] > max_low[p]) begin
                    max_low[p] = low_run[p];
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Output monitor and scoreboard
    // ------------------------------------------------------------------------
    task automatic check_arrival(input int o, input logic [31:0] word);
        int   p;
        pkt_t expected;
        p = port_of_src[word[31:28]];
        if (p < 0 || exp_q[p][o].size() == 0) begin
            $display("Unexpected packet %h on output %0d at %0t", word, o, $time);
            other_errors++;
        end else begin
            expected = exp_q[p][o].pop_front();
            check_value($sformatf("payload_outbound[%0d]", o), word, expected);
            received++;
            // Delivery while some other output is held off
            if (free_outbound != '1) begin
                blocked_arrivals++;
            end
        end
    endtask

    always @(negedge clock) begin
        if (reset_n) begin
            for (int o = 0; o < num_ports; o++) begin
                if (rx_cnt[o] > 0) begin
                    rx_word[o] = {rx_word[o][23:0], payload_outbound[o]};
                    rx_cnt[o]++;
                    if (rx_cnt[o] == 4) begin
                        check_arrival(o, rx_word[o]);
                        rx_cnt[o] = 0;
                    end
                end else if (put_outbound[o]) begin
                    rx_word[o] = {24'h0, payload_outbound[o]};
                    rx_cnt[o]  = 1;
                end
            end
        end
    end

    function automatic bit all_done();
        bit done;
        done = 1'b1;
        for (int p = 0; p < num_ports; p++) begin
            if (pend_start[p].size() != 0 || tx_cnt[p] != 0 || rx_cnt[p] != 0) begin
                done = 1'b0;
            end
            for (int o = 0; o < num_ports; o++) begin
                if (exp_q[p][o].size() != 0) begin
                    done = 1'b0;
                end
            end
        end
        return done;
    endfunction

    task automatic final_checks();
        bit any_stall;
        any_stall = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            for (int o = 0; o < num_ports; o++) begin
                if (exp_q[p][o].size() != 0) begin
                    $display("%0d packets from input %0d to output %0d never arrived",
                             exp_q[p][o].size(), p, o);
                    other_errors++;
                end
            end
            if (stall_expected[p]) begin
                any_stall = 1'b1;
            end
            if (stall_expected[p] && max_low[p] < 2 * fifo_depth) begin
                $display("Input %0d never held off its sender under a full queue", p);
                other_errors++;
            end
        end
        // Other routes must keep moving while one output is blocked
        if (any_stall && blocked_arrivals == 0) begin
            $display("No packet reached a free output while another output was blocked");
            other_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        reset_n          = 1'b0;
        put_inbound      = '0;
        payload_inbound  = '0;
        free_outbound    = '1;
        cycle            = 0;
        last_cycle       = 0;
        first_start      = 1 << 30;
        mismatches       = 0;
        other_errors     = 0;
        sent             = 0;
        received         = 0;
        blocked_arrivals = 0;
        timed_out        = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            tx_cnt[p]         = 0;
            rx_cnt[p]         = 0;
            low_run[p]        = 0;
            max_low[p]        = 0;
            stall_expected[p] = 1'b0;
        end
        load_stimulus();
        repeat (16) @(posedge clock);
        #1;
        reset_n = 1'b1;
        while (!all_done() && !timed_out) begin
            @(posedge clock);
            #1;
            cycle++;
            if (cycle == 1) begin
                check_value("free_inbound", 32'(free_inbound), 32'hf);
            end
            // Nothing leaves before the first packet goes in
            if (cycle <= first_start) begin
                check_value("put_outbound", 32'(put_outbound), 32'h0);
            end
            drive_inputs();
            if (cycle > last_cycle + 400) begin
                $display("Timeout after %0d cycles with packets still outstanding", cycle);
                other_errors++;
                timed_out = 1'b1;
            end
        end
        // Room for late or duplicate packets to show up
        repeat (20) @(posedge clock);
        final_checks();
        $display("Sent %0d received %0d mismatches %0d other errors %0d",
                 sent, received, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/noc_router_properties.sv
`timescale 1ns/1ps

module noc_router_properties import noc_pkg::*; (
    input logic                 clock,
    input logic                 reset_n,
    input logic [num_ports-1:0] free_outbound,
    input logic [num_ports-1:0] free_inbound,
    input logic [num_ports-1:0] put_outbound
);

    // Every input is ready on the first cycle out of reset
    a_free_after_reset: assert property (@(posedge clock) $rose(reset_n) |-> (free_inbound == '1))
        else $error("free_inbound not all high in the first cycle after reset");

    for (genvar i = 0; i < num_ports; i++) begin : g_port
        // Packet start marker lasts one cycle
        a_put_single: assert property (@(posedge clock) disable iff (!reset_n)
            put_outbound[i] |=> !put_outbound[i])
            else $error("put_outbound[%0d] high on two consecutive cycles", i);

        // Receiver was free in the selection cycle
        a_put_when_free: assert property (@(posedge clock) disable iff (!reset_n)
            $rose(put_outbound[i]) |-> $past(free_outbound[i]))
            else $error("put_outbound[%0d] rose without free_outbound in the cycle before", i);
    end

endmodule

bind noc_router noc_router_properties i_noc_router_properties (
    .clock         (clock),
    .reset_n       (reset_n),
    .free_outbound (free_outbound),
    .free_inbound  (free_inbound),
    .put_outbound  (put_outbound)
);

//--- hw/noc_router.sv
`timescale 1ns/1ps

module noc_router import noc_pkg::*; #(
    parameter int router_id = 0
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic  [num_ports-1:0]   put_inbound,
    input  byte_t [num_ports-1:0]   payload_inbound,
    input  logic  [num_ports-1:0]   free_outbound,
    output logic  [num_ports-1:0]   free_inbound,
    output logic  [num_ports-1:0]   put_outbound,
    output byte_t [num_ports-1:0]   payload_outbound
);

    // Input side, one entry per arrival port
    pkt_t  [num_ports-1:0] in_packet;
    logic  [num_ports-1:0] in_valid;
    port_t [num_ports-1:0] in_out_port;
    port_t [num_ports-1:0] in_slot;
    logic  [num_ports-1:0] in_full;

    // Queues indexed by [output port][slot]
    logic [num_ports-1:0][num_sources-1:0] q_write;
    logic [num_ports-1:0][num_sources-1:0] q_read;
    logic [num_ports-1:0][num_sources-1:0] q_full;
    logic [num_ports-1:0][num_sources-1:0] q_empty;
    pkt_t [num_ports-1:0][num_sources-1:0] q_head;

    // ------------------------------------------------------------------------
    // Input ports
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < num_ports; i++) begin : g_in
        input_port #(
            .router_id  (router_id),
            .port_index (i)
        ) i_input_port (
            .clock           (clock),
            .reset_n         (reset_n),
            .put_inbound     (put_inbound[i]),
            .payload_inbound (payload_inbound[i]),
            .queue_full      (in_full[i]),
            .free_inbound    (free_inbound[i]),
            .packet          (in_packet[i]),
            .packet_valid    (in_valid[i]),
            .out_port        (in_out_port[i]),
            .slot            (in_slot[i])
        );
    end

    // ------------------------------------------------------------------------
    // Write steering and full feedback
    // ------------------------------------------------------------------------

    // Each valid input selects exactly one queue
    always_comb begin
        q_write = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (in_valid[i]) begin
                q_write[in_out_port[i]][in_slot[i]] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            in_full[i] = q_full[in_out_port[i]][in_slot[i]];
        end
    end

    // ------------------------------------------------------------------------
    // Queues and output ports
    // ------------------------------------------------------------------------
    for (genvar o = 0; o < num_ports; o++) begin : g_out
        for (genvar s = 0; s < num_sources; s++) begin : g_slot
            // Inverse of queue_slot, the one input that may fill this queue
            localparam int src = (s < o) ? s : s + 1;

            packet_fifo i_packet_fifo (
                .clock    (clock),
                .reset_n  (reset_n),
                .data_in  (in_packet[src]),
                .write    (q_write[o][s]),
                .read     (q_read[o][s]),
                .data_out (q_head[o][s]),
                .full     (q_full[o][s]),
                .empty    (q_empty[o][s])
            );
        end

        output_port i_output_port (
            .clock            (clock),
            .reset_n          (reset_n),
            .free_outbound    (free_outbound[o]),
            .queue_empty      (q_empty[o]),
            .queue_head       (q_head[o]),
            .queue_read       (q_read[o]),
            .put_outbound     (put_outbound[o]),
            .payload_outbound (payload_outbound[o])
        );
    end

endmodule

//--- hw/output_port.sv
`timescale 1ns/1ps

module output_port import noc_pkg::*; (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         free_outbound,
    input  logic [num_sources-1:0]       queue_empty,
    input  pkt_t [num_sources-1:0]       queue_head,
    output logic [num_sources-1:0]       queue_read,
    output logic                         put_outbound,
    output byte_t                        payload_outbound
);

    typedef enum logic [2:0] {
        s_idle,
        s_byte0,
        s_byte1,
        s_byte2,
        s_byte3
    } tx_state_t;

    tx_state_t state;
    port_t     rr_ptr;
    port_t     pick;
    port_t     cand;
    logic      found;
    logic      start;
    pkt_t      pkt_q;

    // ------------------------------------------------------------------------
    // Round-robin selection
    // ------------------------------------------------------------------------

    // First non-empty queue at or after the pointer, wrapping at num_sources
    always_comb begin
        found = 1'b0;
        pick  = rr_ptr;
        cand  = rr_ptr;
        for (int k = 0; k < num_sources; k++) begin
            cand = port_t'((int'(rr_ptr) + k) % num_sources);
            if (!found && !queue_empty[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // Selector only runs between packets
    assign start = (state == s_idle) && free_outbound && found;

    always_comb begin
        queue_read = '0;
        if (start) begin
            queue_read[pick] = 1'b1;
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            rr_ptr <= '0;
        end else if (start) begin
            if (pick == port_t'(num_sources - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= pick + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Byte-serial sender
    // ------------------------------------------------------------------------
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_byte0;
                    end
                end
                s_byte0: state <= s_byte1;
                s_byte1: state <= s_byte2;
                s_byte2: state <= s_byte3;
                s_byte3: state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    // Head is taken in the same cycle the read pulse pops it
    always_ff @(posedge clock) begin
        if (start) begin
            pkt_q <= queue_head[pick];
        end
    end

    assign put_outbound = (state == s_byte0);

    always_comb begin
        case (state)
            s_byte0: payload_outbound = {pkt_q.src, pkt_q.dest};
            s_byte1: payload_outbound = pkt_q.data[23:16];
            s_byte2: payload_outbound = pkt_q.data[15:8];
            s_byte3: payload_outbound = pkt_q.data[7:0];
            default: payload_outbound = 8'h00;
        endcase
    end

endmodule

//--- hw/input_port.sv
`timescale 1ns/1ps

module input_port import noc_pkg::*; #(
    parameter int router_id  = 0,
    parameter int port_index = 0
) (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  put_inbound,
    input  byte_t payload_inbound,
    input  logic  queue_full,
    output logic  free_inbound,
    output pkt_t  packet,
    output logic  packet_valid,
    output port_t out_port,
    output port_t slot
);

    typedef enum logic [1:0] {
        s_idle,
        s_byte1,
        s_byte2,
        s_byte3
    } rx_state_t;

    rx_state_t   state;
    logic [23:0] upper_q;
    logic        held;
    logic        accept;
    pkt_t        assembled;
    port_t       route;
    logic        to_self;

    // ------------------------------------------------------------------------
    // Route decode on the last byte
    // ------------------------------------------------------------------------
    assign assembled = pkt_t'({upper_q, payload_inbound});
    assign route     = route_port(router_id, assembled.dest);
    assign to_self   = (route == port_t'(port_index));

    // No new packet until the hold register drains
    assign free_inbound = (state == s_idle) && !held;
    assign accept       = put_inbound && free_inbound;
    assign packet_valid = held && !queue_full;

    // ------------------------------------------------------------------------
    // Assembler FSM and hold register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state    <= s_idle;
            held     <= 1'b0;
            out_port <= '0;
            slot     <= '0;
        end else begin
            if (packet_valid) begin
                held <= 1'b0;
            end
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_byte1;
                    end
                end
                s_byte1: state <= s_byte2;
                s_byte2: state <= s_byte3;
                s_byte3: begin
                    state <= s_idle;
                    // A packet for our own port has nowhere to go
                    if (!to_self) begin
                        held     <= 1'b1;
                        out_port <= route;
                        slot     <= queue_slot(port_t'(port_index), route);
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Byte capture, most significant first
    always_ff @(posedge clock) begin
        if (state == s_idle && accept) begin
            upper_q[23:16] <= payload_inbound;
        end
        if (state == s_byte1) begin
            upper_q[15:8] <= payload_inbound;
        end
        if (state == s_byte2) begin
            upper_q[7:0] <= payload_inbound;
        end
        if (state == s_byte3 && !to_self) begin
            packet <= assembled;
        end
    end

endmodule

//--- hw/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo import noc_pkg::*; (
    input  logic clock,
    input  logic reset_n,
    input  pkt_t data_in,
    input  logic write,
    input  logic read,
    output pkt_t data_out,
    output logic full,
    output logic empty
);

    pkt_t                  mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  do_write;
    logic                  do_read;

    assign full  = (count == fifo_cnt_w'(fifo_depth));
    assign empty = (count == '0);

    // Overflow and underflow requests are dropped here
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    // Head is always the oldest entry
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

//--- hw/noc_pkg.sv
package noc_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int num_ports   = 4;
    localparam int num_sources = num_ports - 1;
    localparam int fifo_depth  = 8;
    localparam int fifo_ptr_w  = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = fifo_ptr_w + 1;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] node_t;
    typedef logic [1:0] port_t;

    // Source and destination share the first byte on the wire
    typedef struct packed {
        node_t       src;
        node_t       dest;
        logic [23:0] data;
    } pkt_t;

    // ------------------------------------------------------------------------
    // Routing
    // ------------------------------------------------------------------------

    // Output port for a destination node, per router position
    function automatic port_t route_port(input int router_id, input node_t dest);
        port_t p;
        if (router_id == 0) begin
            case (dest)
                4'd0:    p = 2'd0;
                4'd1:    p = 2'd2;
                4'd2:    p = 2'd3;
                default: p = 2'd1;
            endcase
        end else begin
            case (dest)
                4'd3:    p = 2'd0;
                4'd4:    p = 2'd1;
                4'd5:    p = 2'd2;
                default: p = 2'd3;
            endcase
        end
        return p;
    endfunction

    // Queue index at an output; the output's own port has no queue
    function automatic port_t queue_slot(input port_t arrival, input port_t out_port);
        return (arrival < out_port) ? arrival : port_t'(arrival - 2'd1);
    endfunction

endpackage
